//--- Makefile
SIM      = verilator
TOP      = mlpTb
FILELIST = mlp.f
FLAGS    = --binary --timing -j 0
BUILD    = obj_dir
PASSLINE = >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASSLINE)'

clean:
	rm -rf $(BUILD)

//--- design/argmaxSelect.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_cfg.svh"

module argmaxSelect
	import mlpPkg::*;
#(
	parameter int classCount = `MLP_CLASSES
)
(
	input logic clk,
	input logic reset,
	input scoreVector scoresIn,
	output classResult result
);

	classResult best;

	// scan upward and take a later score only when strictly larger
	always_comb
	begin
		best.classIndex = '0;
		best.score = scoresIn.score[0];
		for (int c = 1; c < classCount; c++)
		begin
			if (scoresIn.score[c] > best.score) // both unsigned
			begin
				best.classIndex = classWidth'(c);
				best.score = scoresIn.score[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0; // class 0 with a zero score
		end
		else
		begin
			result <= best;
		end
	end

endmodule

`default_nettype wire

//--- design/denseLayer.sv
`timescale 1ns/1ps
`default_nettype none

module denseLayer
	import mlpPkg::*;
#(
	parameter int inputCount = 4,
	parameter int neuronCount = 3,
	parameter accumulator [0:inputCount*neuronCount-1] weights = '0,
	parameter accumulator [0:neuronCount-1] biases = '0
)
(
	input logic clk,
	input logic reset,
	input accumulator [inputCount-1:0] layerIn,
	output activation [neuronCount-1:0] layerOut
);

	// one copy of the inputs shared by the whole row of neurons
	accumulator [inputCount-1:0] layerInReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			layerInReg <= '0;
		end
		else
		begin
			layerInReg <= layerIn;
		end
	end

	// neuron n takes weight row n and bias n out of the layer tables
	generate
		for (genvar n = 0; n < neuronCount; n++)
		begin : neuron
			neuronNode #(
				.inputCount(inputCount),
				.weights(weights[n*inputCount +: inputCount]),
				.bias(biases[n])
			) node_i (
				.clk(clk),
				.reset(reset),
				.inputs(layerInReg),
				.activationOut(layerOut[n])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- design/mlpPkg.sv
`default_nettype none

`include "mlp_cfg.svh"

package mlpPkg;

	// width of the winning class index
	localparam int classWidth = $clog2(`MLP_CLASSES);

	typedef logic [`MLP_ACT_W-1:0] activation; // unsigned Q13-scaled value
	typedef logic signed [`MLP_ACC_W-1:0] accumulator;

	// one sample entering the network
	typedef struct packed
	{
		activation [`MLP_FEATURES-1:0] feature;
	} featureVector;

	typedef struct packed
	{
		activation [`MLP_HIDDEN-1:0] hidden;
	} hiddenVector;

	// raw output layer activations, one per class
	typedef struct packed
	{
		activation [`MLP_CLASSES-1:0] score;
	} scoreVector;

	typedef struct packed
	{
		logic [classWidth-1:0] classIndex; // lowest index wins a tie
		activation score;
	} classResult;

endpackage

`default_nettype wire

//--- design/mlpTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_cfg.svh"
`include "mlpWeights_cfg.svh"

module mlpTop
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input featureVector features,
	output scoreVector scores,
	output classResult result
);

	localparam int padWidth = `MLP_ACC_W - `MLP_ACT_W;

	accumulator [`MLP_FEATURES-1:0] featureAcc;
	hiddenVector hiddenVec;
	accumulator [`MLP_HIDDEN-1:0] hiddenAcc;

	// activations are unsigned so they enter the layers zero-extended
	generate
		for (genvar f = 0; f < `MLP_FEATURES; f++)
		begin : featurePad
			assign featureAcc[f] = {{padWidth{1'b0}}, features.feature[f]};
		end

		for (genvar h = 0; h < `MLP_HIDDEN; h++)
		begin : hiddenPad
			assign hiddenAcc[h] = {{padWidth{1'b0}}, hiddenVec.hidden[h]};
		end
	endgenerate

	denseLayer #(
		.inputCount(`MLP_FEATURES),
		.neuronCount(`MLP_HIDDEN),
		.weights(`MLP_HIDDEN_WEIGHTS),
		.biases(`MLP_HIDDEN_BIASES)
	) hiddenLayer_i (
		.clk(clk),
		.reset(reset),
		.layerIn(featureAcc),
		.layerOut(hiddenVec.hidden) // valid three edges after sampling
	);

	denseLayer #(
		.inputCount(`MLP_HIDDEN),
		.neuronCount(`MLP_CLASSES),
		.weights(`MLP_OUTPUT_WEIGHTS),
		.biases(`MLP_OUTPUT_BIASES)
	) outputLayer_i (
		.clk(clk),
		.reset(reset),
		.layerIn(hiddenAcc),
		.layerOut(scores.score) // six edges after sampling
	);

	// one more edge for the winner, giving the full latency
	argmaxSelect #(
		.classCount(`MLP_CLASSES)
	) argmax_i (
		.clk(clk),
		.reset(reset),
		.scoresIn(scores),
		.result(result)
	);

endmodule

`default_nettype wire

//--- design/neuronNode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_cfg.svh"

module neuronNode
	import mlpPkg::*;
#(
	parameter int inputCount = 4,
	parameter accumulator [0:inputCount-1] weights = '0,
	parameter accumulator bias = '0
)
(
	input logic clk,
	input logic reset,
	input accumulator [inputCount-1:0] inputs,
	output activation activationOut
);

	accumulator [inputCount-1:0] products;
	accumulator weightedSum;
	accumulator sumReg;

	// every product keeps only its low 32 bits, as the sums do
	always_comb
	begin
		for (int i = 0; i < inputCount; i++)
		begin
			products[i] = inputs[i] * weights[i];
		end
	end

	always_comb
	begin
		weightedSum = bias;
		for (int i = 0; i < inputCount; i++)
		begin
			weightedSum = weightedSum + products[i]; // wraps silently
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= weightedSum;
		end
	end

	// ReLU on the sign bit, then drop the fraction bits
	// bits above the activation window are discarded like the sign
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			activationOut <= '0;
		end
		else if (sumReg[`MLP_ACC_W-1])
		begin
			activationOut <= '0; // negative sum clamps to zero
		end
		else
		begin
			activationOut <= sumReg[`MLP_FRAC +: `MLP_ACT_W];
		end
	end

endmodule

`default_nettype wire

//--- include/mlpWeights_cfg.svh
`ifndef MLP_WEIGHTS_CFG_SVH
`define MLP_WEIGHTS_CFG_SVH

// tables read left to right, so the first word listed is word 0
// word n*inputs+i is the weight from input i into neuron n

// hidden layer, one row of 15 weights per neuron
`define MLP_HIDDEN_WEIGHTS { \
	-32'sd2210,  32'sd3104, -32'sd1875,  32'sd1420,  32'sd5630, \
	 32'sd980,   32'sd2245,  32'sd6120, -32'sd4310,  32'sd1105, \
	 32'sd612,   32'sd1980,  32'sd1377, -32'sd1460, -32'sd3350, \
	 32'sd4120, -32'sd3870,  32'sd2650, -32'sd980,   32'sd1730, \
	-32'sd5220,  32'sd3340,  32'sd870,   32'sd2790, -32'sd1640, \
	 32'sd4460, -32'sd720,   32'sd2085,  32'sd3910, -32'sd2470, \
	 32'sd1530,  32'sd2260, -32'sd4780,  32'sd3650, -32'sd1190, \
	 32'sd2840, -32'sd3020,  32'sd1715,  32'sd960,   32'sd4380, \
	-32'sd2560,  32'sd3175, -32'sd890,   32'sd1240,  32'sd2690, \
	-32'sd3480,  32'sd1090,  32'sd3870, -32'sd2130,  32'sd2410, \
	 32'sd1660, -32'sd1380, -32'sd2945,  32'sd5120, -32'sd860, \
	 32'sd1970,  32'sd2530, -32'sd4210,  32'sd675,   32'sd1845 }

`define MLP_HIDDEN_BIASES { \
	 32'sd480, -32'sd1250,  32'sd2040, -32'sd760 }

// output layer, one row of 4 weights per class
`define MLP_OUTPUT_WEIGHTS { \
	 32'sd6150, -32'sd3240,  32'sd4480, -32'sd1720, \
	-32'sd2860,  32'sd5370, -32'sd1940,  32'sd3810, \
	 32'sd2470,  32'sd1930, -32'sd5060,  32'sd4290 }

`define MLP_OUTPUT_BIASES { \
	 32'sd350, -32'sd820,  32'sd610 }

`endif

//--- include/mlp_cfg.svh
`ifndef MLP_CFG_SVH
`define MLP_CFG_SVH

// network shape
`define MLP_FEATURES 15 // input features per vector
`define MLP_HIDDEN 4
`define MLP_CLASSES 3

// data widths
`define MLP_ACT_W 16 // unsigned activation and score width
`define MLP_ACC_W 32 // products and sums, wrap on overflow

// weights and biases are Q13 so the sum carries 13 fraction bits
`define MLP_FRAC 13

// each dense layer takes three edges and the argmax stage one more
// scores appear one edge before result
`define MLP_LATENCY 7

`endif

//--- mlp.f
+incdir+include
design/mlpPkg.sv
design/neuronNode.sv
design/denseLayer.sv
design/argmaxSelect.sv
design/mlpTop.sv
tests/mlpTb.sv

//--- tests/mlpTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mlp_cfg.svh"
`include "mlpWeights_cfg.svh"

module mlpTb
	import mlpPkg::*;
();

	localparam int clkPeriod = 8;
	localparam int resetCycles = 2;
	localparam int streamCount = 200;
	localparam int directedCount = 4; // single, clamp, wrap and tie vectors
	localparam int flushCount = 5; // one zero flush after each test that drives data
	localparam int totalVectors = resetCycles + streamCount + directedCount
		+ flushCount * `MLP_LATENCY;
	localparam int watchdogTime = 2 * (totalVectors + `MLP_LATENCY + 10) * clkPeriod;

	localparam accumulator [0:`MLP_FEATURES*`MLP_HIDDEN-1] hiddenWeights =
		`MLP_HIDDEN_WEIGHTS;
	localparam accumulator [0:`MLP_HIDDEN-1] hiddenBiases = `MLP_HIDDEN_BIASES;
	localparam accumulator [0:`MLP_HIDDEN*`MLP_CLASSES-1] outputWeights =
		`MLP_OUTPUT_WEIGHTS;
	localparam accumulator [0:`MLP_CLASSES-1] outputBiases = `MLP_OUTPUT_BIASES;

	logic clk = 1'b0;
	logic reset;
	featureVector features;
	scoreVector scores;
	classResult result;

	// expected outputs in the order their vectors entered
	scoreVector expScores[$];
	classResult expClass[$];
	int checkCount = 0;
	int mismatchCount = 0;
	int otherErrors = 0;

	mlpTop dut_i (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.result(result)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// low 32 bits of an exact sum give the wrapped 32-bit result
	function automatic accumulator wrapTo32(input longint value);
		return value[31:0];
	endfunction

	function automatic activation reluScale(input accumulator sum);
		if (sum < 0)
			return '0;
		return activation'(sum >>> `MLP_FRAC);
	endfunction

	function automatic accumulator hiddenSum(input featureVector v, input int n);
		longint acc;
		acc = longint'(hiddenBiases[n]);
		for (int i = 0; i < `MLP_FEATURES; i++)
			acc += longint'(v.feature[i]) * longint'(hiddenWeights[n*`MLP_FEATURES + i]);
		return wrapTo32(acc);
	endfunction

	function automatic hiddenVector modelHidden(input featureVector v);
		hiddenVector h;
		for (int n = 0; n < `MLP_HIDDEN; n++)
			h.hidden[n] = reluScale(hiddenSum(v, n));
		return h;
	endfunction

	function automatic accumulator outputSum(input hiddenVector h, input int n);
		longint acc;
		acc = longint'(outputBiases[n]);
		for (int i = 0; i < `MLP_HIDDEN; i++)
			acc += longint'(h.hidden[i]) * longint'(outputWeights[n*`MLP_HIDDEN + i]);
		return wrapTo32(acc);
	endfunction

	function automatic scoreVector modelScores(input featureVector v);
		hiddenVector h;
		scoreVector s;
		h = modelHidden(v);
		for (int n = 0; n < `MLP_CLASSES; n++)
			s.score[n] = reluScale(outputSum(h, n));
		return s;
	endfunction

	// largest score wins and an equal later score does not displace it
	function automatic classResult pickClass(input scoreVector s);
		classResult best;
		best.classIndex = '0;
		best.score = s.score[0];
		for (int n = 1; n < `MLP_CLASSES; n++)
		begin
			if (s.score[n] > best.score)
			begin
				best.classIndex = classWidth'(n);
				best.score = s.score[n];
			end
		end
		return best;
	endfunction

	task automatic checkScores(input scoreVector expected);
		for (int n = 0; n < `MLP_CLASSES; n++)
		begin
			checkCount++;
			if (scores.score[n] !== expected.score[n])
			begin
				mismatchCount++;
				$display("MISMATCH time %0t scores.score[%0d] expected %0d actual %0d",
					$time, n, expected.score[n], scores.score[n]);
			end
		end
	endtask

	task automatic checkClass(input classResult expected);
		checkCount++;
		if (result.classIndex !== expected.classIndex)
		begin
			mismatchCount++;
			$display("MISMATCH time %0t result.classIndex expected %0d actual %0d",
				$time, expected.classIndex, result.classIndex);
		end
		if (result.score !== expected.score)
		begin
			mismatchCount++;
			$display("MISMATCH time %0t result.score expected %0d actual %0d",
				$time, expected.score, result.score);
		end
	endtask

	// outputs are read on the falling edge, well away from the driving edge
	task automatic applyVector(input featureVector v);
		scoreVector s;
		s = modelScores(v);
		@(posedge clk);
		features <= v;
		expScores.push_back(s);
		expClass.push_back(pickClass(s));
		@(negedge clk);
		checkScores(expScores.pop_front()); // vector from six edges back
		checkClass(expClass.pop_front()); // and seven for the class
	endtask

	task automatic flushPipeline();
		repeat (`MLP_LATENCY) applyVector('0);
	endtask

	task automatic releaseReset();
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkScores('0);
		checkClass('0);
		// features were zero through reset, so every stage in flight holds the zero vector
		repeat (`MLP_LATENCY - 1) expScores.push_back(modelScores('0));
		repeat (`MLP_LATENCY) expClass.push_back(pickClass(modelScores('0)));
	endtask

	task automatic sendSingleVector();
		featureVector v;
		for (int i = 0; i < `MLP_FEATURES; i++)
			v.feature[i] = 16'(1500 + 3100 * i);
		applyVector(v);
		flushPipeline();
	endtask

	task automatic clampNegativeSums();
		featureVector v;
		int negatives;
		v = '0;
		v.feature[0] = 16'd40000; // large input on a column with negative weights
		negatives = 0;
		for (int n = 0; n < `MLP_HIDDEN; n++)
			if (hiddenSum(v, n) < 0)
				negatives++;
		for (int n = 0; n < `MLP_CLASSES; n++)
			if (outputSum(modelHidden(v), n) < 0)
				negatives++;
		if (negatives == 0)
		begin
			otherErrors++;
			$display("clamp vector left every neuron sum non-negative in the model");
		end
		applyVector(v);
		flushPipeline();
	endtask

	task automatic streamRandomVectors();
		featureVector v;
		for (int k = 0; k < streamCount; k++)
		begin
			for (int i = 0; i < `MLP_FEATURES; i++)
				v.feature[i] = activation'($urandom());
			applyVector(v);
		end
		flushPipeline();
	endtask

	task automatic wideSumsAndTies();
		featureVector big;
		featureVector tie;
		accumulator sum;
		scoreVector s;
		classResult winner;
		int tied;
		// full scale on every positive weight of neuron 0 sets bits above bit 28
		big = '0;
		for (int i = 0; i < `MLP_FEATURES; i++)
			if (hiddenWeights[i] > 0)
				big.feature[i] = 16'hFFFF;
		sum = hiddenSum(big, 0);
		if (sum < 0 || sum[31:29] == 3'b000)
		begin
			otherErrors++;
			$display("large vector did not carry hidden sum 0 past the activation bits");
		end
		applyVector(big);
		flushPipeline();
		for (int i = 0; i < `MLP_FEATURES; i++)
			tie.feature[i] = 16'd1;
		s = modelScores(tie);
		winner = pickClass(s);
		tied = 0;
		for (int n = 0; n < `MLP_CLASSES; n++)
			if (s.score[n] == winner.score)
				tied++;
		if (tied < 2)
		begin
			otherErrors++;
			$display("tie vector gave a single highest score in the model");
		end
		applyVector(tie);
		flushPipeline();
	endtask

	initial
	begin
		reset = 1'b1;
		features = '0;
		void'($urandom(10041));
		releaseReset();
		sendSingleVector();
		clampNegativeSums();
		streamRandomVectors();
		wideSumsAndTies();
		$display("checks %0d, mismatches %0d, other errors %0d",
			checkCount, mismatchCount, otherErrors);
		if (mismatchCount == 0 && otherErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		#(watchdogTime);
		$display("timeout after %0d ns with the tests still running", watchdogTime);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
